// ==== run_sim.sh ====
#!/bin/sh
# compile and run the edge fetch unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_edge_job_control \
	-f src.f -o sim_edge

./obj_dir/sim_edge | tee sim.log

if grep -qF "*** TEST PASSED ***" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed, see sim.log"
	exit 1
fi

// ==== src.f ====
verilog/edge_pkg.sv
verilog/edge_read_sequencer.sv
verilog/edge_line_assembler.sv
verilog/edge_job_fifo.sv
verilog/edge_job_control.sv
verif/tb_edge_job_control.sv

// ==== verif/edge_vectors.txt ====
// first line: src_base dest_base weight_base
// then one job per line: id edge_idx degree expected_commands expected_edges (hex)
00010000 00020000 00030000
// aligned, one full line
1 0 8 3 8
// misaligned over three lines, sizes 3 8 2
2 5 d 9 d
// degree 0, nothing issued
3 28 0 0 0
4 10 4 3 4
// long job, fills the edge FIFO
5 3 28 12 28
6 64 14 9 14
7 7 1 3 1
ffffffff

// ==== verif/tb_edge_job_control.sv ====
`timescale 1ns/1ps
// testbench for the edge fetch unit, jobs and bases come from verif/edge_vectors.txt
// memory model answers every word with its own byte address
// inputs change 1 ns after the rising edge, outputs are read at that same point
// a job larger than the edge FIFO is left unpopped until the FIFO fills

module tb_edge_job_control;
	import edge_pkg::*;

	localparam int VEC_WORDS  = 64;
	localparam int WAIT_LIMIT = 4000;
	localparam int SETTLE     = 8;
	localparam int HOLD_FULL  = 20;

	logic        clock;
	logic        rstn;
	vertex_job_t vertex_job;
	array_base_t array_base;
	read_data_t  read_data;
	logic        edge_pop;
	read_cmd_t   read_cmd;
	edge_job_t   edge_job;
	logic        edge_empty;

	logic [31:0]        vec [VEC_WORDS];
	read_cmd_t          exp_cmd_q [$];
	edge_job_t          exp_edge_q [$];
	// responses waiting for their delay to run out
	logic [ADDR_W-1:0]  pend_addr [$];
	array_sel_e         pend_sel [$];
	int                 pend_due [$];
	logic [COUNT_W-1:0] next_edge_id;
	int                 errors;
	int                 tests_run;
	int                 tests_failed;
	int                 cmd_count;
	int                 edge_count;
	bit                 pop_hold;
	bit                 timed_out;

	edge_job_control dut0 (
		.clock     (clock),
		.rstn      (rstn),
		.vertex_job(vertex_job),
		.array_base(array_base),
		.read_data (read_data),
		.edge_pop  (edge_pop),
		.read_cmd  (read_cmd),
		.edge_job  (edge_job),
		.edge_empty(edge_empty)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////

	function automatic logic [LINE_W-1:0] make_line(input logic [ADDR_W-1:0] addr);
		logic [LINE_W-1:0] line;
		for (int i = 0; i < LINE_EDGES; i++)
			line[i*EDGE_W +: EDGE_W] = addr + ADDR_W'(i * EDGE_BYTES);
		return line;
	endfunction

	function automatic bit drained();
		return exp_cmd_q.size() == 0 && exp_edge_q.size() == 0 &&
			pend_due.size() == 0 && edge_empty;
	endfunction

	task automatic compare_word(input string name, input logic [31:0] got,
		input logic [31:0] want);
		if (got !== want) begin
			$display("[FAIL] %s got %h expected %h", name, got, want);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int err_start);
		tests_run++;
		if (errors == err_start) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - err_start);
		end
	endtask

	// expected commands and edges straight from the chunking rule
	task automatic plan_job(input logic [COUNT_W-1:0] idx, input logic [COUNT_W-1:0] degree);
		int        offset;
		int        remaining;
		int        rem;
		int        size;
		read_cmd_t cmd;
		edge_job_t e;
		offset    = idx * EDGE_BYTES;
		remaining = degree;
		while (remaining > 0) begin
			rem  = offset % CACHELINE_BYTES;
			size = (CACHELINE_BYTES - rem) / EDGE_BYTES;
			if (remaining < size)
				size = remaining;
			cmd             = '0;
			cmd.valid       = 1'b1;
			cmd.real_size   = SIZE_W'(size);
			cmd.line_offset = LINE_IDX_W'(rem / EDGE_BYTES);
			cmd.array_sel   = ARRAY_SRC;
			cmd.address     = array_base.src_base + ADDR_W'(offset - rem);
			exp_cmd_q.push_back(cmd);
			cmd.array_sel   = ARRAY_DEST;
			cmd.address     = array_base.dest_base + ADDR_W'(offset - rem);
			exp_cmd_q.push_back(cmd);
			cmd.array_sel   = ARRAY_WEIGHT;
			cmd.address     = array_base.weight_base + ADDR_W'(offset - rem);
			exp_cmd_q.push_back(cmd);
			offset    += size * EDGE_BYTES;
			remaining -= size;
		end
		for (int k = 0; k < degree; k++) begin
			e        = '0;
			e.valid  = 1'b1;
			e.id     = next_edge_id;
			e.src    = array_base.src_base + ADDR_W'((idx + k) * EDGE_BYTES);
			e.dest   = array_base.dest_base + ADDR_W'((idx + k) * EDGE_BYTES);
			e.weight = array_base.weight_base + ADDR_W'((idx + k) * EDGE_BYTES);
			next_edge_id++;
			exp_edge_q.push_back(e);
		end
	endtask

	task automatic run_job(input logic [31:0] id, input logic [31:0] idx,
		input logic [31:0] degree, input logic [31:0] want_cmds, input logic [31:0] want_edges);
		int    err_start;
		int    cycles;
		int    cmds_at_full;
		string name;
		err_start = errors;
		name      = $sformatf("job %0d", id);
		plan_job(idx[COUNT_W-1:0], degree[COUNT_W-1:0]);
		cmd_count           = 0;
		edge_count          = 0;
		pop_hold            = (degree > EDGE_FIFO_DEPTH);
		vertex_job.valid    = 1'b1;
		vertex_job.id       = id[COUNT_W-1:0];
		vertex_job.edge_idx = idx[COUNT_W-1:0];
		vertex_job.degree   = degree[COUNT_W-1:0];
		if (pop_hold) begin
			cycles = 0;
			while (!dut0.fifo_full && cycles < WAIT_LIMIT) begin
				@(posedge clock);
				#1;
				cycles++;
			end
			if (!dut0.fifo_full) begin
				$display("timeout waiting for the edge FIFO to fill in %s", name);
				timed_out = 1'b1;
			end
			// stay full a while, the sequencer must stall meanwhile
			cmds_at_full = cmd_count;
			repeat (HOLD_FULL) @(posedge clock);
			#1;
			compare_word("read_cmd count while FIFO full", 32'(cmd_count),
				32'(cmds_at_full));
			pop_hold = 1'b0;
		end
		if (!timed_out) begin
			cycles = 0;
			while ((cycles < SETTLE || !drained()) && cycles < WAIT_LIMIT) begin
				@(posedge clock);
				#1;
				cycles++;
			end
			if (!drained()) begin
				$display("timeout waiting for %s to finish its commands and edges", name);
				timed_out = 1'b1;
			end
			compare_word("command count", 32'(cmd_count), want_cmds);
			compare_word("edge count", 32'(edge_count), want_edges);
		end
		report_test(name, err_start);
	endtask

	//////////////////////////////////////////////////
	// memory responder, 1 to 6 cycles per line
	//////////////////////////////////////////////////

	initial begin : responder
		int        cyc;
		int        pick;
		read_cmd_t want;
		cyc       = 0;
		read_data = '0;
		forever begin
			@(posedge clock);
			#1;
			cyc++;
			read_data = '0;
			pick      = -1;
			for (int i = 0; i < pend_due.size(); i++)
				if (pick < 0 && pend_due[i] <= cyc)
					pick = i;
			if (pick >= 0) begin
				read_data.valid     = 1'b1;
				read_data.array_sel = pend_sel[pick];
				read_data.data      = make_line(pend_addr[pick]);
				pend_addr.delete(pick);
				pend_sel.delete(pick);
				pend_due.delete(pick);
			end
			if (rstn && read_cmd.valid) begin
				cmd_count++;
				if (exp_cmd_q.size() == 0) begin
					$display("read command to %h came with none expected", read_cmd.address);
					errors++;
				end else begin
					want = exp_cmd_q.pop_front();
					compare_word("read_cmd.array_sel", 32'(read_cmd.array_sel),
						32'(want.array_sel));
					compare_word("read_cmd.address", read_cmd.address, want.address);
					compare_word("read_cmd.real_size", 32'(read_cmd.real_size),
						32'(want.real_size));
					compare_word("read_cmd.line_offset", 32'(read_cmd.line_offset),
						32'(want.line_offset));
				end
				pend_addr.push_back(read_cmd.address);
				pend_sel.push_back(read_cmd.array_sel);
				pend_due.push_back(cyc + int'($urandom_range(6, 1)));
			end
		end
	end

	// edge consumer with random pop gaps
	initial begin : consumer
		edge_job_t want;
		edge_pop = 1'b0;
		forever begin
			@(posedge clock);
			#1;
			edge_pop = 1'b0;
			if (rstn && !pop_hold && edge_job.valid && $urandom_range(3, 0) != 0) begin
				edge_count++;
				if (exp_edge_q.size() == 0) begin
					$display("edge with id %h came with none expected", edge_job.id);
					errors++;
				end else begin
					want = exp_edge_q.pop_front();
					compare_word("edge_job.id", 32'(edge_job.id), 32'(want.id));
					compare_word("edge_job.src", edge_job.src, want.src);
					compare_word("edge_job.dest", edge_job.dest, want.dest);
					compare_word("edge_job.weight", edge_job.weight, want.weight);
				end
				edge_pop = 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////

	initial begin : main
		int job;
		int err_start;
		void'($urandom(32'h2e32984d));
		rstn         = 1'b0;
		vertex_job   = '0;
		array_base   = '0;
		pop_hold     = 1'b0;
		timed_out    = 1'b0;
		next_edge_id = '0;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		for (int i = 0; i < VEC_WORDS; i++)
			vec[i] = '1;
		$readmemh("verif/edge_vectors.txt", vec);
		array_base.src_base    = vec[0];
		array_base.dest_base   = vec[1];
		array_base.weight_base = vec[2];

		repeat (10) @(posedge clock);
		#1;
		rstn = 1'b1;
		@(posedge clock);
		#1;
		err_start = errors;
		compare_word("read_cmd.valid", 32'(read_cmd.valid), 32'h0);
		compare_word("edge_job.valid", 32'(edge_job.valid), 32'h0);
		compare_word("edge_empty", 32'(edge_empty), 32'h1);
		report_test("reset values", err_start);

		job = 3;
		while (!timed_out && job + 4 < VEC_WORDS && vec[job] !== 32'hffffffff) begin
			run_job(vec[job], vec[job+1], vec[job+2], vec[job+3], vec[job+4]);
			job += 5;
		end

		if (tests_run < 2)
			$display("no vertex jobs were read from the vectors file");
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0 && !timed_out && tests_run > 1) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// ==== verilog/edge_job_control.sv ====
`timescale 1ns/1ps
// edge fetch unit: read sequencer, line assembler and edge FIFO
// read commands have no ready, the memory side must always accept them
// array_base must stay constant while jobs are in flight

module edge_job_control (
	input  logic                  clock,
	input  logic                  rstn,
	input  edge_pkg::vertex_job_t vertex_job,
	input  edge_pkg::array_base_t array_base,
	input  edge_pkg::read_data_t  read_data,
	input  logic                  edge_pop,
	output edge_pkg::read_cmd_t   read_cmd,
	output edge_pkg::edge_job_t   edge_job,
	output logic                  edge_empty
);
	import edge_pkg::*;

	read_cmd_t line_request;
	logic      assembler_busy;
	edge_job_t fifo_push;
	logic      fifo_full;

	// the assembler sees every command as it leaves
	assign read_cmd = line_request;

	edge_read_sequencer u_seq (
		.clock         (clock),
		.rstn          (rstn),
		.vertex_job    (vertex_job),
		.array_base    (array_base),
		.assembler_busy(assembler_busy),
		.read_cmd      (line_request)
	);

	edge_line_assembler u_asm (
		.clock         (clock),
		.rstn          (rstn),
		.read_cmd      (line_request),
		.read_data     (read_data),
		.fifo_full     (fifo_full),
		.assembler_busy(assembler_busy),
		.fifo_push     (fifo_push)
	);

	edge_job_fifo u_fifo (
		.clock(clock),
		.rstn (rstn),
		.push (fifo_push),
		.pop  (edge_pop),
		.full (fifo_full),
		.empty(edge_empty),
		.head (edge_job)
	);

endmodule

// ==== verilog/edge_job_fifo.sv ====
`timescale 1ns/1ps
// circular edge FIFO with a registered head entry
// head.valid is high exactly while the FIFO holds an entry
// depth must be a power of two, pointers wrap naturally

module edge_job_fifo (
	input  logic                clock,
	input  logic                rstn,
	input  edge_pkg::edge_job_t push,
	input  logic                pop,
	output logic                full,
	output logic                empty,
	output edge_pkg::edge_job_t head
);
	import edge_pkg::*;

	edge_job_t             mem [EDGE_FIFO_DEPTH];
	logic [FIFO_PTR_W-1:0] wr_ptr;
	logic [FIFO_PTR_W-1:0] rd_ptr;
	logic [FIFO_PTR_W-1:0] rd_next;
	logic [FIFO_PTR_W:0]   count;
	logic [FIFO_PTR_W:0]   count_next;
	logic                  do_push;
	logic                  do_pop;
	logic                  head_from_push;
	edge_job_t             head_next;

	assign full    = (count == (FIFO_PTR_W+1)'(EDGE_FIFO_DEPTH));
	assign empty   = (count == '0);
	assign do_push = push.valid && !full;
	assign do_pop  = pop && !empty;
	assign rd_next = do_pop ? rd_ptr + 1'b1 : rd_ptr;

	assign count_next = count + do_push - do_pop;

	// new head is the incoming entry when nothing older remains
	assign head_from_push = empty || (do_pop && count == (FIFO_PTR_W+1)'(1));

	always_comb begin
		if (count_next == '0)
			head_next = '0;
		else if (head_from_push)
			head_next = push;
		else
			head_next = mem[rd_next];
		head_next.valid = (count_next != '0);
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			head   <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			rd_ptr <= rd_next;
			count  <= count_next;
			head   <= head_next;
		end
	end

	always_ff @(posedge clock) begin
		if (do_push)
			mem[wr_ptr] <= push;
	end

	a_no_push_full: assert property (@(posedge clock) disable iff (!rstn)
		push.valid |-> !full);

	a_no_pop_empty: assert property (@(posedge clock) disable iff (!rstn)
		pop |-> !empty);

endmodule

// ==== verilog/edge_line_assembler.sv ====
`timescale 1ns/1ps
// gathers the src, dest and weight lines of one chunk and emits its edges
// each command must get exactly one response, responses may come in any order
// the edge id runs from reset and is never cleared

module edge_line_assembler (
	input  logic                 clock,
	input  logic                 rstn,
	input  edge_pkg::read_cmd_t  read_cmd,
	input  edge_pkg::read_data_t read_data,
	input  logic                 fifo_full,
	output logic                 assembler_busy,
	output edge_pkg::edge_job_t  fifo_push
);
	import edge_pkg::*;

	logic [1:0]            outstanding;
	// one bit per array_sel
	logic [2:0]            line_ready;
	logic [SIZE_W-1:0]     edges_left;
	logic [LINE_IDX_W-1:0] edge_sel;
	logic [COUNT_W-1:0]    edge_id;
	logic [LINE_W-1:0]     src_line;
	logic [LINE_W-1:0]     dest_line;
	logic [LINE_W-1:0]     weight_line;
	logic                  emit;
	logic                  last_edge;

	assign emit      = assembler_busy && (&line_ready) && (outstanding == '0) && !fifo_full;
	assign last_edge = emit && (edges_left == SIZE_W'(1));

	//////////////////////////////////////////////////
	// response tracking and edge walk
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			outstanding    <= '0;
			line_ready     <= '0;
			assembler_busy <= 1'b0;
			edges_left     <= '0;
			edge_sel       <= '0;
			edge_id        <= '0;
		end else begin
			if (read_cmd.valid && !read_data.valid)
				outstanding <= outstanding + 2'd1;
			else if (!read_cmd.valid && read_data.valid)
				outstanding <= outstanding - 2'd1;

			// src command opens the chunk
			if (read_cmd.valid && read_cmd.array_sel == ARRAY_SRC) begin
				assembler_busy <= 1'b1;
				edges_left     <= read_cmd.real_size;
				edge_sel       <= read_cmd.line_offset;
			end

			if (read_data.valid)
				line_ready[read_data.array_sel] <= 1'b1;

			if (emit) begin
				edge_id    <= edge_id + 1'b1;
				edge_sel   <= edge_sel + 1'b1;
				edges_left <= edges_left - 1'b1;
			end

			// chunk done, lines free for the next triple
			if (last_edge) begin
				assembler_busy <= 1'b0;
				line_ready     <= '0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (read_data.valid) begin
			case (read_data.array_sel)
				ARRAY_SRC:    src_line    <= read_data.data;
				ARRAY_DEST:   dest_line   <= read_data.data;
				ARRAY_WEIGHT: weight_line <= read_data.data;
				default:      ;
			endcase
		end
	end

	always_comb begin
		fifo_push        = '0;
		fifo_push.valid  = emit;
		fifo_push.id     = edge_id;
		fifo_push.src    = src_line[edge_sel*EDGE_W +: EDGE_W];
		fifo_push.dest   = dest_line[edge_sel*EDGE_W +: EDGE_W];
		fifo_push.weight = weight_line[edge_sel*EDGE_W +: EDGE_W];
	end

	a_resp_expected: assert property (@(posedge clock) disable iff (!rstn)
		read_data.valid |-> (outstanding != '0));

	// sequencer must hold off a new triple until the chunk has drained
	a_no_overlap: assert property (@(posedge clock) disable iff (!rstn)
		(read_cmd.valid && read_cmd.array_sel == ARRAY_SRC) |-> !assembler_busy);

endmodule

// ==== verilog/edge_pkg.sv ====
// shared sizes, enums and bus structs of the edge fetch unit
// sizes are scaled down: 32 byte cachelines of 4 byte edges, 8 edges per line
// edge i of a line sits at data bits [32i+31:32i], lowest address in the low bits
// EDGE_FIFO_DEPTH must stay a power of two

package edge_pkg;

	localparam int ADDR_W          = 32;
	localparam int EDGE_W          = 32;
	localparam int CACHELINE_BYTES = 32;
	localparam int EDGE_BYTES      = 4;
	localparam int LINE_EDGES      = CACHELINE_BYTES / EDGE_BYTES;
	localparam int LINE_W          = CACHELINE_BYTES * 8;
	localparam int COUNT_W         = 16;
	localparam int EDGE_FIFO_DEPTH = 16;

	// derived widths
	localparam int BYTE_OFF_W = $clog2(CACHELINE_BYTES);
	localparam int EDGE_SHIFT = $clog2(EDGE_BYTES);
	localparam int LINE_IDX_W = $clog2(LINE_EDGES);
	localparam int SIZE_W     = LINE_IDX_W + 1;
	localparam int FIFO_PTR_W = $clog2(EDGE_FIFO_DEPTH);

	typedef enum logic [1:0] {
		ARRAY_SRC,
		ARRAY_DEST,
		ARRAY_WEIGHT
	} array_sel_e;

	typedef enum logic [2:0] {
		IDLE,
		LOAD,
		WAIT,
		CALC,
		ISSUE_SRC,
		ISSUE_DEST,
		ISSUE_WEIGHT
	} seq_state_e;

	typedef struct packed {
		logic               valid;
		logic [COUNT_W-1:0] id;
		logic [COUNT_W-1:0] edge_idx;
		logic [COUNT_W-1:0] degree;
	} vertex_job_t;

	typedef struct packed {
		logic [ADDR_W-1:0] src_base;
		logic [ADDR_W-1:0] dest_base;
		logic [ADDR_W-1:0] weight_base;
	} array_base_t;

	// one line read, address is line aligned
	typedef struct packed {
		logic                  valid;
		array_sel_e            array_sel;
		logic [ADDR_W-1:0]     address;
		logic [SIZE_W-1:0]     real_size;
		logic [LINE_IDX_W-1:0] line_offset;
	} read_cmd_t;

	typedef struct packed {
		logic              valid;
		array_sel_e        array_sel;
		logic [LINE_W-1:0] data;
	} read_data_t;

	typedef struct packed {
		logic               valid;
		logic [COUNT_W-1:0] id;
		logic [EDGE_W-1:0]  src;
		logic [EDGE_W-1:0]  dest;
		logic [EDGE_W-1:0]  weight;
	} edge_job_t;

endpackage

// ==== verilog/edge_read_sequencer.sv ====
`timescale 1ns/1ps
// splits a vertex job into cacheline chunks, three reads per chunk
// a job is taken only if its id differs from the last accepted one
// commands are single cycle pulses, the read port is assumed to always accept
// a new chunk waits until the assembler has drained the previous one

module edge_read_sequencer (
	input  logic                  clock,
	input  logic                  rstn,
	input  edge_pkg::vertex_job_t vertex_job,
	input  edge_pkg::array_base_t array_base,
	input  logic                  assembler_busy,
	output edge_pkg::read_cmd_t   read_cmd
);
	import edge_pkg::*;

	seq_state_e         state;
	seq_state_e         next_state;
	vertex_job_t        job_q;
	logic               accept;
	logic [COUNT_W-1:0] edges_left;
	logic [ADDR_W-1:0]  byte_offset;

	// chunk arithmetic
	logic [BYTE_OFF_W-1:0] remainder;
	logic [ADDR_W-1:0]     aligned_offset;
	logic [LINE_IDX_W-1:0] calc_offset;
	logic [SIZE_W-1:0]     line_room;
	logic [SIZE_W-1:0]     calc_size;

	// held for the three issue cycles
	logic [ADDR_W-1:0]     chunk_aligned;
	logic [SIZE_W-1:0]     chunk_size;
	logic [LINE_IDX_W-1:0] chunk_offset;

	assign accept = (state == IDLE) && vertex_job.valid &&
		(!job_q.valid || (vertex_job.id != job_q.id));

	assign remainder      = byte_offset[BYTE_OFF_W-1:0];
	assign aligned_offset = byte_offset - ADDR_W'(remainder);
	assign calc_offset    = remainder[BYTE_OFF_W-1:EDGE_SHIFT];
	assign line_room      = SIZE_W'(LINE_EDGES) - SIZE_W'(calc_offset);
	assign calc_size      = (edges_left < COUNT_W'(line_room)) ?
		edges_left[SIZE_W-1:0] : line_room;

	//////////////////////////////////////////////////
	// state machine
	//////////////////////////////////////////////////

	always_comb begin
		next_state = state;
		case (state)
			IDLE: begin
				if (accept)
					next_state = LOAD;
			end
			LOAD: begin
				// degree 0 jobs end here
				if (job_q.degree == '0)
					next_state = IDLE;
				else if (assembler_busy)
					next_state = WAIT;
				else
					next_state = CALC;
			end
			WAIT: begin
				if (!assembler_busy)
					next_state = CALC;
			end
			CALC:         next_state = ISSUE_SRC;
			ISSUE_SRC:    next_state = ISSUE_DEST;
			ISSUE_DEST:   next_state = ISSUE_WEIGHT;
			ISSUE_WEIGHT: next_state = (edges_left != '0) ? WAIT : IDLE;
			default:      next_state = IDLE;
		endcase
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state       <= IDLE;
			job_q       <= '0;
			edges_left  <= '0;
			byte_offset <= '0;
		end else begin
			state <= next_state;
			if (accept)
				job_q <= vertex_job;
			if (state == LOAD) begin
				edges_left  <= job_q.degree;
				byte_offset <= ADDR_W'(job_q.edge_idx) << EDGE_SHIFT;
			end
			if (state == CALC) begin
				edges_left  <= edges_left - COUNT_W'(calc_size);
				// next chunk always starts on a line boundary
				byte_offset <= aligned_offset + ADDR_W'(CACHELINE_BYTES);
			end
		end
	end

	always_ff @(posedge clock) begin
		if (state == CALC) begin
			chunk_aligned <= aligned_offset;
			chunk_size    <= calc_size;
			chunk_offset  <= calc_offset;
		end
	end

	//////////////////////////////////////////////////
	// command output, src then dest then weight
	//////////////////////////////////////////////////

	always_comb begin
		read_cmd = '0;
		case (state)
			ISSUE_SRC: begin
				read_cmd.array_sel = ARRAY_SRC;
				read_cmd.address   = array_base.src_base + chunk_aligned;
			end
			ISSUE_DEST: begin
				read_cmd.array_sel = ARRAY_DEST;
				read_cmd.address   = array_base.dest_base + chunk_aligned;
			end
			ISSUE_WEIGHT: begin
				read_cmd.array_sel = ARRAY_WEIGHT;
				read_cmd.address   = array_base.weight_base + chunk_aligned;
			end
			default: read_cmd.array_sel = ARRAY_SRC;
		endcase
		if (state == ISSUE_SRC || state == ISSUE_DEST || state == ISSUE_WEIGHT) begin
			read_cmd.valid       = 1'b1;
			read_cmd.real_size   = chunk_size;
			read_cmd.line_offset = chunk_offset;
		end
	end

	// chunk size comes from the edge count loaded two states earlier
	a_no_empty_cmd: assert property (@(posedge clock) disable iff (!rstn)
		read_cmd.valid |-> (read_cmd.real_size != '0));

endmodule
